//--- build.f
logic/ifu_pkg.sv
logic/ifu_fetch_ctl.sv
logic/ifu_bus_fetch.sv
logic/ifu_aligner.sv
logic/ifu_top.sv
verif/ifu_assertions.sv
verif/ifu_tb.sv

//--- logic/ifu_aligner.sv
// Aligner with halfword fetch buffer, instruction extraction, PC tracking and fault marking
`default_nettype none

module ifu_aligner #(
   parameter ifu_pkg::pc_t RESET_PC                 // PC of first parcel after reset
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,               // Empty buffer, load PC
   input  ifu_pkg::pc_t        flush_addr,
   input  ifu_pkg::fetch_rsp_t rsp,                 // Word from the bus
   output logic                room,                // A full word still fits
   input  logic                instr_ready,         // Decode takes packet
   output logic                instr_valid,
   output ifu_pkg::instr_pkt_t instr
);
   import ifu_pkg::*;

   half_t [3:0] hw_q;                               // Parcel 0 is oldest
   logic  [3:0] flt_q;                              // Fault per parcel
   logic  [2:0] cnt_q;                              // Parcels held, 0 to 4
   pc_t         pc_q;                               // PC of parcel 0
   logic        skip_q;                             // Drop low half of next word

   half_t [3:0] hw_n;
   logic  [3:0] flt_n;
   logic  [2:0] cnt_n;
   logic  [1:0] wr_idx;                             // First free slot
   logic  [1:0] wr_idx_hi;
   logic        is32;                               // Low bits 11
   logic        have_two;
   logic        first_flt;
   logic        second_flt;
   logic        pkt_fault;
   logic        fire;                               // Packet transfers

   // *********************************************************
   // Extraction
   // *********************************************************
   assign is32       = (hw_q[0][1:0] == 2'b11);
   assign have_two   = (cnt_q >= 3'd2);
   assign first_flt  = flt_q[0];
   assign second_flt = is32 & flt_q[1];             // Upper half in error region
   assign pkt_fault  = first_flt | second_flt;

   // A faulting first parcel has no size, report it alone
   assign instr_valid = (cnt_q != 3'd0) & (first_flt | ~is32 | have_two);
   assign fire        = instr_valid & instr_ready;
   assign room        = (cnt_q <= 3'd2);

   always_comb begin
      instr.pc    = pc_q;
      instr.pc4   = is32 & ~first_flt;
      instr.fault = pkt_fault;
      if (pkt_fault) begin
         instr.instr = '0;                          // No data on access fault
      end else if (is32) begin
         instr.instr = {hw_q[1], hw_q[0]};
      end else begin
         instr.instr = {16'h0000, hw_q[0]};         // Compressed, zero filled
      end
   end

   // *********************************************************
   // Buffer update
   // *********************************************************
   always_comb begin
      hw_n  = hw_q;
      flt_n = flt_q;
      cnt_n = cnt_q;
      if (fire) begin
         if (pkt_fault) begin
            cnt_n = 3'd0;                           // Fetch stops, one report only
         end else if (is32) begin
            hw_n[1:0]  = hw_q[3:2];
            flt_n[1:0] = flt_q[3:2];
            cnt_n      = cnt_q - 3'd2;
         end else begin
            hw_n[2:0]  = hw_q[3:1];
            flt_n[2:0] = flt_q[3:1];
            cnt_n      = cnt_q - 3'd1;
         end
      end
      wr_idx    = cnt_n[1:0];                       // At most 2 when a word lands
      wr_idx_hi = wr_idx + 2'd1;
      if (rsp.valid) begin
         if (skip_q) begin
            hw_n[wr_idx]  = rsp.data[31:16];        // Target sits in upper half
            flt_n[wr_idx] = rsp.fault;
            cnt_n         = cnt_n + 3'd1;
         end else begin
            hw_n[wr_idx]     = rsp.data[15:0];
            hw_n[wr_idx_hi]  = rsp.data[31:16];
            flt_n[wr_idx]    = rsp.fault;
            flt_n[wr_idx_hi] = rsp.fault;
            cnt_n            = cnt_n + 3'd2;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt_q  <= 3'd0;
         pc_q   <= RESET_PC;
         skip_q <= RESET_PC[0];                     // Odd halfword boot
      end else if (flush) begin
         cnt_q  <= 3'd0;
         pc_q   <= flush_addr;
         skip_q <= flush_addr[0];
      end else begin
         cnt_q <= cnt_n;
         if (fire) begin
            pc_q <= pc_q + (is32 ? pc_t'(2) : pc_t'(1));  // Plus 4 or 2 bytes
         end
         if (rsp.valid) begin
            skip_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      hw_q  <= hw_n;
      flt_q <= flt_n;
   end

endmodule

`default_nettype wire

//--- logic/ifu_bus_fetch.sv
// Wishbone classic read master with one cycle in flight and stale response discard
`default_nettype none

module ifu_bus_fetch (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,               // Marks an open cycle stale
   input  ifu_pkg::fetch_req_t req,                 // Word request
   output logic                req_taken,           // Cycle starts on req
   output logic                bus_idle,            // Ready for a new req
   output logic                wb_cyc,
   output logic                wb_stb,
   output ifu_pkg::word_t      wb_adr,
   input  logic                wb_ack,
   input  logic                wb_err,
   input  ifu_pkg::word_t      wb_rdata,
   output ifu_pkg::fetch_rsp_t rsp                  // Data of a live cycle
);
   import ifu_pkg::*;

   bus_state_t state;
   bus_state_t state_nxt;
   wadr_t      adr_q;                               // Latched word address
   logic       bus_done;                            // Slave ends the cycle

   assign bus_done  = wb_ack | wb_err;
   assign bus_idle  = (state == BUS_IDLE);
   assign req_taken = bus_idle & req.valid;

   // Cycle and strobe stay up until the slave answers, flushed or not
   assign wb_cyc = (state != BUS_IDLE);
   assign wb_stb = (state != BUS_IDLE);
   assign wb_adr = {adr_q, 2'b00};

   // *********************************************************
   // Bus FSM
   // *********************************************************
   always_comb begin
      state_nxt = state;
      case (state)
         BUS_IDLE: begin
            if (req_taken) state_nxt = BUS_ACTIVE;
         end
         BUS_ACTIVE: begin
            if (bus_done) begin
               state_nxt = BUS_IDLE;                // Idle one cycle between cycles
            end else if (flush) begin
               state_nxt = BUS_DISCARD;
            end
         end
         BUS_DISCARD: begin
            if (bus_done) state_nxt = BUS_IDLE;
         end
         default: state_nxt = BUS_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= BUS_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (req_taken) begin
         adr_q <= req.addr;
      end
   end

   // *********************************************************
   // Response
   // *********************************************************

   // Same cycle as ack, aligner registers it at the next edge
   always_comb begin
      rsp.valid = (state == BUS_ACTIVE) & bus_done & ~flush;
      rsp.fault = wb_err;                           // Error wins over ack
      rsp.data  = wb_rdata;
   end

endmodule

`default_nettype wire

//--- logic/ifu_fetch_ctl.sv
// Fetch control with word address register, flush redirect, halt flag and request generation
`default_nettype none

module ifu_fetch_ctl #(
   parameter ifu_pkg::pc_t RESET_PC                 // Boot PC from top
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,               // Redirect from execute
   input  logic                flush_halt,          // Stop after redirect
   input  ifu_pkg::pc_t        flush_addr,          // New halfword PC
   input  logic                room,                // Aligner fits a word
   input  logic                bus_idle,            // No bus cycle open
   input  logic                req_taken,           // Bus started our word
   input  ifu_pkg::fetch_rsp_t rsp,                 // Finished bus cycle
   output ifu_pkg::fetch_req_t req                  // Word request
);
   import ifu_pkg::*;

   wadr_t fetch_addr;                               // Next word to read
   logic  fetch_en;                                 // Low when halted or faulted
   logic  fault_seen;                               // Error ended a live cycle

   assign fault_seen = rsp.valid & rsp.fault;

   // *********************************************************
   // Request
   // *********************************************************

   // One word at a time, never in the flush cycle since the address is stale
   always_comb begin
      req.valid = fetch_en & bus_idle & room & ~flush;
      req.addr  = fetch_addr;                       // Held until taken
   end

   // *********************************************************
   // Address and enable
   // *********************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_addr <= RESET_PC[PC_W-1:1];          // Word holding boot PC
         fetch_en   <= 1'b1;
      end else if (flush) begin
         fetch_addr <= flush_addr[PC_W-1:1];        // Drop halfword bit
         fetch_en   <= ~flush_halt;
      end else begin
         if (req_taken) begin
            fetch_addr <= fetch_addr + 1'b1;        // Next sequential word
         end
         if (fault_seen) begin
            fetch_en <= 1'b0;                       // Wait for a flush
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/ifu_pkg.sv
// Fetch unit widths, bus state enum and the packets between fetch stages
`default_nettype none

package ifu_pkg;

   // *********************************************************
   // Widths
   // *********************************************************
   localparam int WORD_W = 32;            // Bus and instruction word
   localparam int HALF_W = 16;            // Compressed parcel
   localparam int PC_W   = WORD_W - 1;    // PC bits 31:1
   localparam int WADR_W = WORD_W - 2;    // Word address bits 31:2

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [HALF_W-1:0] half_t;
   typedef logic [PC_W-1:0]   pc_t;       // Halfword granular
   typedef logic [WADR_W-1:0] wadr_t;     // Word granular

   // *********************************************************
   // Stage packets
   // *********************************************************

   // Fetch control to bus fetch
   typedef struct packed {
      logic  valid;                       // Word wanted
      wadr_t addr;                        // Word to read
   } fetch_req_t;

   // Bus fetch to aligner and fetch control
   typedef struct packed {
      logic  valid;                       // One cycle per finished bus cycle
      logic  fault;                       // Ended by wb_err
      word_t data;                        // Read data
   } fetch_rsp_t;

   // Aligner to decode
   typedef struct packed {
      word_t instr;                       // Upper half zero when compressed
      pc_t   pc;                          // PC of first parcel
      logic  pc4;                         // 32-bit instruction
      logic  fault;                       // Access fault, data zeroed
   } instr_pkt_t;

   // Wishbone read master states
   typedef enum logic [1:0] {
      BUS_IDLE,                           // No cycle open
      BUS_ACTIVE,                         // Live cycle waiting for ack
      BUS_DISCARD                         // Flushed cycle, drop its data
   } bus_state_t;

endpackage

`default_nettype wire

//--- logic/ifu_top.sv
// Fetch unit top level joining fetch control, bus fetch and aligner
`default_nettype none

module ifu_top #(
   parameter ifu_pkg::pc_t RESET_PC = 31'h0000_0080  // Boot at byte address 0x100
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,                // Redirect
   input  logic                flush_halt,           // Redirect and stop
   input  ifu_pkg::pc_t        flush_addr,
   output logic                wb_cyc,               // Wishbone classic master
   output logic                wb_stb,
   output ifu_pkg::word_t      wb_adr,
   input  logic                wb_ack,
   input  logic                wb_err,
   input  ifu_pkg::word_t      wb_rdata,
   input  logic                instr_ready,          // Decode handshake
   output logic                instr_valid,
   output ifu_pkg::instr_pkt_t instr
);
   import ifu_pkg::*;

   fetch_req_t fetch_req;                            // Control to bus
   fetch_rsp_t fetch_rsp;                            // Bus to aligner and control
   logic       req_taken;
   logic       bus_idle;
   logic       room;

   ifu_fetch_ctl #(
      .RESET_PC   (RESET_PC)
   ) i_fetch_ctl (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .flush_halt (flush_halt),
      .flush_addr (flush_addr),
      .room       (room),
      .bus_idle   (bus_idle),
      .req_taken  (req_taken),
      .rsp        (fetch_rsp),
      .req        (fetch_req)
   );

   ifu_bus_fetch i_bus_fetch (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .req        (fetch_req),
      .req_taken  (req_taken),
      .bus_idle   (bus_idle),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_adr     (wb_adr),
      .wb_ack     (wb_ack),
      .wb_err     (wb_err),
      .wb_rdata   (wb_rdata),
      .rsp        (fetch_rsp)
   );

   ifu_aligner #(
      .RESET_PC    (RESET_PC)
   ) i_aligner (
      .clk         (clk),
      .rst         (rst),
      .flush       (flush),
      .flush_addr  (flush_addr),
      .rsp         (fetch_rsp),
      .room        (room),
      .instr_ready (instr_ready),
      .instr_valid (instr_valid),
      .instr       (instr)
   );

endmodule

`default_nettype wire

//--- verif/ifu_assertions.sv
// Wishbone and decode handshake assertions bound to the fetch unit top level
`default_nettype none

module ifu_assertions (
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  ifu_pkg::word_t      wb_adr,
   input  logic                wb_ack,
   input  logic                wb_err,
   input  logic                instr_ready,
   input  logic                instr_valid,
   input  ifu_pkg::instr_pkt_t instr
);
   timeunit 1ns;
   timeprecision 100ps;
   import ifu_pkg::*;

   int fail_cnt = 0;                                      // Read by the testbench

   // *********************************************************
   // Wishbone classic
   // *********************************************************
   stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
      else begin
         $error("wb_stb high without wb_cyc");
         fail_cnt++;
      end

   adr_held: assert property (@(posedge clk) disable iff (rst)
                              (wb_stb && !wb_ack && !wb_err) |=> (wb_stb && $stable(wb_adr)))
      else begin
         $error("wb_adr or wb_stb changed before the slave answered");
         fail_cnt++;
      end

   // *********************************************************
   // Decode handshake
   // *********************************************************
   pkt_held: assert property (@(posedge clk) disable iff (rst)
                              (instr_valid && !instr_ready && !flush)
                              |=> (instr_valid && $stable(instr)))
      else begin
         $error("Instruction packet changed while decode stalled");
         fail_cnt++;
      end

   quiet_after_rst: assert property (@(posedge clk) rst |=> !instr_valid)
      else begin
         $error("instr_valid high right after reset");
         fail_cnt++;
      end

endmodule

bind ifu_top ifu_assertions i_ifu_assertions (
   .clk         (clk),
   .rst         (rst),
   .flush       (flush),
   .wb_cyc      (wb_cyc),
   .wb_stb      (wb_stb),
   .wb_adr      (wb_adr),
   .wb_ack      (wb_ack),
   .wb_err      (wb_err),
   .instr_ready (instr_ready),
   .instr_valid (instr_valid),
   .instr       (instr)
);

`default_nettype wire

//--- verif/ifu_tb.sv
// Fetch unit testbench with clock, reset, Wishbone memory model, decode model, reference and tests
`default_nettype none

module ifu_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import ifu_pkg::*;

   localparam pc_t   BOOT_PC     = 31'h0000_0080;         // Byte 0x100
   localparam wadr_t FAULT_WADR  = 30'h0000_0400;         // Error region from here up
   localparam pc_t   FAULT_H     = {FAULT_WADR, 1'b0};    // Same boundary in halfwords
   localparam int    T1_INSTR    = 200;
   localparam int    T2_INSTR    = 40;
   localparam int    T3_INSTR    = 30;
   localparam int    T5_INSTR    = 300;
   localparam int    HALT_WATCH  = 50;
   localparam int    FAULT_WATCH = 30;
   // Worst case about 16 cycles per instruction with ready at half rate
   localparam int    CYCLE_LIMIT = 16 * (T1_INSTR + T2_INSTR + T3_INSTR + T5_INSTR)
                                   + HALT_WATCH + 3 * FAULT_WATCH + 600;

   logic       clk;
   logic       rst;
   logic       flush;
   logic       flush_halt;
   pc_t        flush_addr;
   logic       wb_cyc;
   logic       wb_stb;
   word_t      wb_adr;
   logic       wb_ack;
   logic       wb_err;
   word_t      wb_rdata;
   logic       instr_ready;
   logic       instr_valid;
   instr_pkt_t instr;

   logic [31:0] lfsr_q     = 32'd81628;                   // Shared random state
   logic        ready_mode = 1'b0;                        // 0 always ready, 1 random
   pc_t         exp_pc;                                   // Next expected PC
   logic        stopped;                                  // Halted or faulted
   logic        stb_prev   = 1'b0;
   int          err_cnt    = 0;
   int          err_mark   = 0;
   int          test_cnt   = 0;
   int          xfer_cnt   = 0;
   int          fault_cnt  = 0;
   int          cross_cnt  = 0;                           // 32-bit across a word edge
   int          stb_cnt    = 0;                           // Rising strobes
   int          cycle_cnt  = 0;

   ifu_top #(
      .RESET_PC    (BOOT_PC)
   ) i_ifu_top (
      .clk         (clk),
      .rst         (rst),
      .flush       (flush),
      .flush_halt  (flush_halt),
      .flush_addr  (flush_addr),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_adr      (wb_adr),
      .wb_ack      (wb_ack),
      .wb_err      (wb_err),
      .wb_rdata    (wb_rdata),
      .instr_ready (instr_ready),
      .instr_valid (instr_valid),
      .instr       (instr)
   );

   // *********************************************************
   // Random bits and memory image
   // *********************************************************
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);  // Galois, right shift
   endfunction

   function automatic logic [3:0] rand_bits(input int n);
      logic [3:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);                      // One step per bit
         v = {v[2:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // Parcel at a halfword address, about 3 in 8 start a 32-bit instruction
   function automatic half_t half_at(input pc_t h);
      half_t mix;
      mix = (h[15:0] ^ {1'b0, h[30:16]}) * 16'h9e37;
      mix = mix ^ 16'h5a3c;
      if (h == FAULT_H - 31'd1 || mix[7:5] > 3'd4) begin
         mix[1:0] = 2'b11;                                // Last parcel before errors is 32-bit
      end else if (mix[1:0] == 2'b11) begin
         mix[1:0] = 2'b01;
      end
      return mix;
   endfunction

   function automatic word_t word_at(input wadr_t w);
      return {half_at({w, 1'b1}), half_at({w, 1'b0})};
   endfunction

   // Expected packet at a PC from size, fault and zero fill rules
   function automatic instr_pkt_t ref_pkt(input pc_t pc);
      instr_pkt_t p;
      half_t      lo;
      lo      = half_at(pc);
      p.pc    = pc;
      p.pc4   = 1'b0;
      p.fault = 1'b0;
      p.instr = '0;
      if (pc >= FAULT_H) begin
         p.fault = 1'b1;                                  // First parcel in error region
      end else if (lo[1:0] == 2'b11) begin
         p.pc4 = 1'b1;
         if (pc + 31'd1 >= FAULT_H) begin
            p.fault = 1'b1;                               // Upper parcel faulted
         end else begin
            p.instr = {half_at(pc + 31'd1), lo};
         end
      end else begin
         p.instr = {16'h0000, lo};
      end
      return p;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, want);
         err_cnt++;
      end
   endtask

   // *********************************************************
   // Clock, models, comparison, timeout
   // *********************************************************
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                              // 8 ns period
   end

   initial begin : bus_and_decode_models
      logic       busy;
      logic [3:0] wait_left;
      wadr_t      w;
      busy        = 1'b0;
      wait_left   = '0;
      wb_ack      = 1'b0;
      wb_err      = 1'b0;
      wb_rdata    = '0;
      instr_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         wb_ack   = 1'b0;
         wb_err   = 1'b0;
         wb_rdata = '0;
         if (rst) begin
            busy = 1'b0;
         end else begin
            if (wb_stb && !busy) begin
               busy      = 1'b1;
               wait_left = rand_bits(2);                  // 0 to 3 wait cycles
               check_value("wb_adr[1:0]", wb_adr[1:0], 2'b00);  // Whole words only
            end
            if (busy) begin
               if (wait_left == 4'd0) begin
                  w        = wb_adr[31:2];
                  busy     = 1'b0;
                  wb_rdata = word_at(w);                  // Image data even with an error
                  if (w >= FAULT_WADR) begin
                     wb_err = 1'b1;
                  end else begin
                     wb_ack = 1'b1;
                  end
               end else begin
                  wait_left = wait_left - 4'd1;
               end
            end
         end
         instr_ready = ready_mode ? (rand_bits(1) != 4'd0) : 1'b1;
      end
   end

   // Inputs settle 1 ns after the edge, so the falling edge sees stable values
   always @(negedge clk) begin : compare_stream
      instr_pkt_t want;
      if (rst) begin
         exp_pc  = BOOT_PC;
         stopped = 1'b0;
      end else if (flush) begin
         exp_pc  = flush_addr;                            // Old path dies here
         stopped = flush_halt;
      end else if (instr_valid && instr_ready) begin
         xfer_cnt++;
         if (stopped) begin
            $display("Instruction at pc %h transferred while fetch was stopped", instr.pc);
            err_cnt++;
         end else begin
            want = ref_pkt(exp_pc);
            check_value("instr.instr", instr.instr, want.instr);
            check_value("instr.pc", instr.pc, want.pc);
            check_value("instr.pc4", instr.pc4, want.pc4);
            check_value("instr.fault", instr.fault, want.fault);
            if (want.pc4 && exp_pc[0]) cross_cnt++;
            if (want.fault) begin
               fault_cnt++;
               stopped = 1'b1;                            // Nothing until next flush
            end
            exp_pc = exp_pc + (want.pc4 ? 31'd2 : 31'd1);
         end
      end
      if (wb_stb && !stb_prev) stb_cnt++;
      stb_prev = wb_stb;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the instruction stream stopped", cycle_cnt);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // *********************************************************
   // Test sequence
   // *********************************************************
   task automatic sync_edge();
      @(posedge clk);
      #1;
   endtask

   task automatic redirect(input pc_t addr, input logic halt);
      flush      = 1'b1;
      flush_halt = halt;
      flush_addr = addr;
      sync_edge();
      flush      = 1'b0;
      flush_halt = 1'b0;
   endtask

   task automatic wait_transfers(input int n);
      int target;
      target = xfer_cnt + n;
      while (xfer_cnt < target) sync_edge();
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   initial begin : run_tests
      pc_t fault_starts [3];
      int  fault_mark;
      int  stb_mark;
      int  xfer_mark;
      int  total_err;
      fault_starts = '{FAULT_H - 31'd6, FAULT_H - 31'd1, FAULT_H + 31'd1};
      rst        = 1'b1;
      flush      = 1'b0;
      flush_halt = 1'b0;
      flush_addr = '0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      wait_transfers(T1_INSTR);
      if (cross_cnt == 0) begin
         $display("No 32-bit instruction crossed a word boundary in the boot stream");
         err_cnt++;
      end
      end_test("boot_stream");

      while (!wb_stb) sync_edge();                        // Flush over an open cycle
      redirect(31'h0000_0301, 1'b0);
      wait_transfers(T2_INSTR);
      end_test("flush_odd_halfword");

      while (!wb_stb) sync_edge();
      redirect(31'h0000_0200, 1'b1);
      while (wb_cyc) sync_edge();                         // Stale cycle runs out
      stb_mark  = stb_cnt;
      xfer_mark = xfer_cnt;
      repeat (HALT_WATCH) sync_edge();
      check_value("stb_cnt", stb_cnt, stb_mark);
      check_value("xfer_cnt", xfer_cnt, xfer_mark);
      redirect(31'h0000_0401, 1'b0);
      wait_transfers(T3_INSTR);
      end_test("flush_halt");

      foreach (fault_starts[i]) begin
         fault_mark = fault_cnt;
         redirect(fault_starts[i], 1'b0);
         while (fault_cnt == fault_mark) sync_edge();
         while (wb_cyc) sync_edge();
         stb_mark = stb_cnt;
         repeat (FAULT_WATCH) sync_edge();
         check_value("stb_cnt", stb_cnt, stb_mark);      // Bus stays quiet
      end
      end_test("access_fault");

      ready_mode = 1'b1;
      redirect(31'h0000_0141, 1'b0);
      wait_transfers(T5_INSTR);
      end_test("random_ready");

      total_err = err_cnt + i_ifu_top.i_ifu_assertions.fail_cnt;
      $display("%0d tests, %0d transfers, %0d faults, %0d assertion failures, %0d errors",
               test_cnt, xfer_cnt, fault_cnt, i_ifu_top.i_ifu_assertions.fail_cnt,
               total_err);
      if (total_err == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire
